// File: descriptor_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "msgst_ld_tg_defines.svh"

module descriptor_rom
	import msgst_ld_pkg::*;
(
	fill_if.rom fill
);

	logic [`MSGST_CMD_WORDS-1:0][31:0] st_word;
	logic [`MSGLD_CMD_WORDS-1:0][31:0] ld_word;
	logic [31:0]                       pld_word;
	logic [31:0]                       word_sel;

	////////////////////////////////////////////////////////////
	// Store descriptor, reserved bits zero
	////////////////////////////////////////////////////////////
	assign st_word[0] = {2'h0, `MSGST_ADDR_TRANSLATED, 1'b0, `MSGST_FNC, 1'b0,
		`MSGST_OP, `MSGST_PLD_LENGTH};
	assign st_word[1] = {`MSGST_START_OFFSET, `MSGST_CSI_DST, `MSGST_WC_OP,
		`MSGST_WC_TIMEOUT_IDX, `MSGST_WC_LINE_SIZE, `MSGST_WC_ID};
	assign st_word[2] = {4'h0, `MSGST_CSI_DST_FIFO, `MSGST_CLIENT_ID, `MSGST_DATA_WIDTH,
		`MSGST_RESP_COOKIE, `MSGST_RESP_REQ};
	assign st_word[3] = {`MSGST_PRIV_MODE_RQ, `MSGST_EXECUTE_RQ, `MSGST_PATTERN,
		`MSGST_SEED, `MSGST_WAIT_PLD_PKT_ID, `MSGST_ST2M_ORDERED, `MSGST_IDO,
		`MSGST_RO, `MSGST_NO_SNOOP};
	assign st_word[4] = {5'h0, `MSGST_ST_HI, `MSGST_PH, `MSGST_TH, `MSGST_IRQ_VECTOR};
	assign st_word[5] = {`MSGST_PASID, `MSGST_ENABLE, `MSGST_ECC};

	////////////////////////////////////////////////////////////
	// Load descriptor
	////////////////////////////////////////////////////////////
	assign ld_word[0] = {`MSGLD_ADDR_TRANSLATED, 1'b0, `MSGLD_FNC, 1'b0,
		`MSGLD_RELAXED_READ, `MSGLD_DATA_WIDTH, `MSGLD_OP, `MSGLD_LENGTH};
	assign ld_word[1] = {1'b0, `MSGLD_START_OFFSET, `MSGLD_CSI_DST_FIFO, `MSGLD_CSI_DST,
		`MSGLD_OP_1, `MSGLD_CLIENT_ID, `MSGLD_RC_ID};
	assign ld_word[2] = {7'h0, `MSGLD_PATTERN, `MSGLD_SEED, `MSGLD_IDO, `MSGLD_RO,
		`MSGLD_NO_SNOOP, `MSGLD_RESP_COOKIE};
	assign ld_word[3] = {9'h0, `MSGLD_PRIV_MODE_RQ, `MSGLD_EXECUTE_RQ, `MSGLD_PASID,
		`MSGLD_ENABLE};

	// Byte index pattern, byte 4i in the low lane
	assign pld_word = {3'b000, fill.word_idx, 2'd3,
		3'b000, fill.word_idx, 2'd2,
		3'b000, fill.word_idx, 2'd1,
		3'b000, fill.word_idx, 2'd0};

	always_comb
	begin
		word_sel = '0;
		case (fill.region)
			region_msgst_cmd:
			begin
				if (fill.word_idx < 3'(`MSGST_CMD_WORDS))
					word_sel = st_word[fill.word_idx];
			end
			region_msgld_cmd:
			begin
				if (fill.word_idx < 3'(`MSGLD_CMD_WORDS))
					word_sel = ld_word[fill.word_idx];
			end
			region_msgst_pld: word_sel = pld_word;
			default:          word_sel = '0;   // Unused region code
		endcase
	end

	assign fill.word = word_sel;

endmodule

`default_nettype wire

// File: fill_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "msgst_ld_tg_defines.svh"

module fill_counter
	import msgst_ld_pkg::*;
(
	input  wire  fabric_clk,
	input  wire  fabric_rst_n,
	fill_if.cnt  fill
);

	logic [2:0]  idx_q;
	logic [31:0] addr_q;
	logic [2:0]  last_idx;
	logic [31:0] base;

	// Region geometry
	always_comb
	begin
		case (fill.region)
			region_msgld_cmd:
			begin
				base     = `MSGLD_CMD_BASE;
				last_idx = 3'(`MSGLD_CMD_WORDS - 1);
			end
			region_msgst_pld:
			begin
				base     = `MSGST_PLD_BASE;
				last_idx = 3'(`MSGST_PLD_WORDS - 1);
			end
			default:
			begin
				base     = `MSGST_CMD_BASE;
				last_idx = 3'(`MSGST_CMD_WORDS - 1);
			end
		endcase
	end

	always_ff @(posedge fabric_clk)
	begin
		if (!fabric_rst_n)
		begin
			idx_q  <= '0;
			addr_q <= '0;
		end
		else if (fill.start || (fill.advance && fill.last))
		begin
			idx_q  <= '0;     // Back to the region base
			addr_q <= base;
		end
		else if (fill.advance)
		begin
			idx_q  <= idx_q + 3'd1;
			addr_q <= addr_q + 32'd4;   // One 32-bit word
		end
	end

	assign fill.word_idx  = idx_q;
	assign fill.word_addr = addr_q;
	assign fill.last      = (idx_q == last_idx);

endmodule

`default_nettype wire

// File: fill_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fill_if
	import msgst_ld_pkg::*;
();

	fill_region_e region;
	logic         start;      // First word of a fill
	logic         advance;    // Response done
	logic [2:0]   word_idx;
	logic [31:0]  word_addr;
	logic         last;
	logic [31:0]  word;

	modport seq (
		output region, start, advance,
		input  word_addr, word, last
	);

	modport cnt (
		input  region, start, advance,
		output word_idx, word_addr, last
	);

	modport rom (
		input  region, word_idx,
		output word
	);

endinterface

`default_nettype wire

// File: fill_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fill_sequencer
	import msgst_ld_pkg::*;
(
	input  wire         fabric_clk,
	input  wire         fabric_rst_n,
	input  wire         msgst_cmd_fill,
	input  wire         msgld_cmd_fill,
	input  wire         msgst_pld_fill,
	fill_if.seq         fill,
	output logic [31:0] awaddr,
	output logic        awvalid,
	input  wire         awready,
	output logic [31:0] wdata,
	output logic        wvalid,
	input  wire         wready,
	input  wire         bvalid,
	output logic        bready
);

	wr_phase_e    state_q;
	fill_region_e region_q;
	fill_region_e region_pick;
	logic         any_req;
	logic         cur_req;
	logic         resp_done;

	////////////////////////////////////////////////////////////
	// Request arbitration
	////////////////////////////////////////////////////////////

	// Store cmd over load cmd over payload
	always_comb
	begin
		if (msgst_cmd_fill)
			region_pick = region_msgst_cmd;
		else if (msgld_cmd_fill)
			region_pick = region_msgld_cmd;
		else
			region_pick = region_msgst_pld;
	end

	assign any_req = msgst_cmd_fill | msgld_cmd_fill | msgst_pld_fill;

	// Level of the request that owns the running fill
	always_comb
	begin
		case (region_q)
			region_msgst_cmd: cur_req = msgst_cmd_fill;
			region_msgld_cmd: cur_req = msgld_cmd_fill;
			region_msgst_pld: cur_req = msgst_pld_fill;
			default:          cur_req = 1'b0;
		endcase
	end

	// Counter sees the new region in the same cycle as start
	always_comb
	begin
		if (state_q == phase_idle)
			fill.region = region_pick;
		else
			fill.region = region_q;
	end

	assign resp_done    = (state_q == phase_resp) && bvalid && bready;
	assign fill.start   = (state_q == phase_idle) && any_req;
	assign fill.advance = resp_done;

	assign awaddr = fill.word_addr;   // Held in the counter, steady while awvalid is up

	////////////////////////////////////////////////////////////
	// Write phases
	////////////////////////////////////////////////////////////
	always_ff @(posedge fabric_clk)
	begin
		if (!fabric_rst_n)
		begin
			state_q  <= phase_idle;
			region_q <= region_msgst_cmd;
			awvalid  <= 1'b0;
			wvalid   <= 1'b0;
			bready   <= 1'b0;
			wdata    <= '0;
		end
		else
		begin
			case (state_q)
				phase_idle:
				begin
					if (any_req)
					begin
						region_q <= region_pick;   // Fixed until the fill ends
						awvalid  <= 1'b1;
						state_q  <= phase_addr;
					end
				end
				phase_addr:
				begin
					if (awvalid && awready)
					begin
						awvalid <= 1'b0;
						wvalid  <= 1'b1;
						wdata   <= fill.word;
						state_q <= phase_data;
					end
				end
				phase_data:
				begin
					if (wvalid && wready)
					begin
						wvalid  <= 1'b0;
						bready  <= 1'b1;
						state_q <= phase_resp;
					end
				end
				phase_resp:
				begin
					if (resp_done)
					begin
						bready <= 1'b0;
						// Stop only at the region end with the level dropped
						if (fill.last && !cur_req)
							state_q <= phase_idle;
						else
						begin
							awvalid <= 1'b1;
							state_q <= phase_addr;
						end
					end
				end
				default: state_q <= phase_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: msgst_ld_pkg.sv
`default_nettype none

package msgst_ld_pkg;

	// BRAM region under fill
	typedef enum logic [1:0] {
		region_msgst_cmd = 2'd0,
		region_msgld_cmd = 2'd1,
		region_msgst_pld = 2'd2
	} fill_region_e;

	// AXI4-Lite write phases of the sequencer
	typedef enum logic [1:0] {
		phase_idle = 2'd0,
		phase_addr = 2'd1,
		phase_data = 2'd2,
		phase_resp = 2'd3
	} wr_phase_e;

endpackage

`default_nettype wire

// File: msgst_ld_tg.f
+incdir+.
msgst_ld_pkg.sv
fill_if.sv
fill_sequencer.sv
fill_counter.sv
descriptor_rom.sv
msgst_ld_tg.sv
tb_msgst_ld_tg.sv

// File: msgst_ld_tg.sv
`timescale 1ns/1ps
`default_nettype none

module msgst_ld_tg
(
	input  wire         fabric_clk,
	input  wire         fabric_rst_n,

	// Fill request levels
	input  wire         msgst_cmd_fill,
	input  wire         msgld_cmd_fill,
	input  wire         msgst_pld_fill,

	// AXI4-Lite write master
	output logic [31:0] awaddr,
	output logic [2:0]  awprot,
	output logic        awvalid,
	input  wire         awready,
	output logic [31:0] wdata,
	output logic [3:0]  wstrb,
	output logic        wvalid,
	input  wire         wready,
	input  wire  [1:0]  bresp,
	input  wire         bvalid,
	output logic        bready
);

	fill_if fill ();

	fill_sequencer u_seq (
		.fabric_clk     (fabric_clk),
		.fabric_rst_n   (fabric_rst_n),
		.msgst_cmd_fill (msgst_cmd_fill),
		.msgld_cmd_fill (msgld_cmd_fill),
		.msgst_pld_fill (msgst_pld_fill),
		.fill           (fill.seq),
		.awaddr         (awaddr),
		.awvalid        (awvalid),
		.awready        (awready),
		.wdata          (wdata),
		.wvalid         (wvalid),
		.wready         (wready),
		.bvalid         (bvalid),
		.bready         (bready)
	);

	fill_counter u_cnt (
		.fabric_clk   (fabric_clk),
		.fabric_rst_n (fabric_rst_n),
		.fill         (fill.cnt)
	);

	descriptor_rom u_rom (
		.fill (fill.rom)
	);

	// Unprivileged data access, whole-word writes only
	assign awprot = 3'b000;
	assign wstrb  = 4'hf;

endmodule

`default_nettype wire

// File: msgst_ld_tg_defines.svh
`ifndef MSGST_LD_TG_DEFINES_SVH
`define MSGST_LD_TG_DEFINES_SVH

////////////////////////////////////////////////////////////
// Message BRAM regions
////////////////////////////////////////////////////////////
`define MSGST_CMD_BASE           32'h0000_0000
`define MSGLD_CMD_BASE           32'h0000_4000
`define MSGST_PLD_BASE           32'h0000_8000

`define MSGST_CMD_WORDS          6
`define MSGLD_CMD_WORDS          4
`define MSGST_PLD_WORDS          8

////////////////////////////////////////////////////////////
// Message store descriptor fields
////////////////////////////////////////////////////////////
// Word 0
`define MSGST_PLD_LENGTH         9'h100     // Payload bytes
`define MSGST_OP                 2'h0       // Store msg
`define MSGST_FNC                16'h0
`define MSGST_ADDR_TRANSLATED    1'b0
// Word 1
`define MSGST_WC_ID              16'h0
`define MSGST_WC_LINE_SIZE       1'b1       // 128B lines
`define MSGST_WC_TIMEOUT_IDX     3'h7
`define MSGST_WC_OP              2'h0
`define MSGST_CSI_DST            5'h4       // PCIe
`define MSGST_START_OFFSET       5'h0
// Word 2
`define MSGST_RESP_REQ           1'b1
`define MSGST_RESP_COOKIE        12'hbdf
`define MSGST_DATA_WIDTH         2'h1
`define MSGST_CLIENT_ID          4'h0       // Fabric port 0
`define MSGST_CSI_DST_FIFO       9'h0
// Word 3
`define MSGST_NO_SNOOP           1'b0
`define MSGST_RO                 1'b0
`define MSGST_IDO                1'b0
`define MSGST_ST2M_ORDERED       1'b0
`define MSGST_WAIT_PLD_PKT_ID    16'h0
`define MSGST_SEED               8'h1f
`define MSGST_PATTERN            2'h0       // LFSR
`define MSGST_EXECUTE_RQ         1'b0
`define MSGST_PRIV_MODE_RQ       1'b0
// Word 4, TPH hints
`define MSGST_IRQ_VECTOR         16'h0
`define MSGST_TH                 1'b0
`define MSGST_PH                 2'h0
`define MSGST_ST_HI              8'h0
// Word 5
`define MSGST_ECC                11'h0
`define MSGST_ENABLE             1'b0
`define MSGST_PASID              20'h0

////////////////////////////////////////////////////////////
// Message load descriptor fields
////////////////////////////////////////////////////////////
// Word 0
`define MSGLD_LENGTH             9'h100
`define MSGLD_OP                 2'h0       // Load msg
`define MSGLD_DATA_WIDTH         1'b1
`define MSGLD_RELAXED_READ       1'b0
`define MSGLD_FNC                16'h0
`define MSGLD_ADDR_TRANSLATED    1'b0
// Word 1
`define MSGLD_RC_ID              6'ha
`define MSGLD_CLIENT_ID          4'h0
`define MSGLD_OP_1               2'h0
`define MSGLD_CSI_DST            5'h4
`define MSGLD_CSI_DST_FIFO       9'h0
`define MSGLD_START_OFFSET       5'h0
// Word 2
`define MSGLD_RESP_COOKIE        12'hbdf
`define MSGLD_NO_SNOOP           1'b0
`define MSGLD_RO                 1'b0
`define MSGLD_IDO                1'b0
`define MSGLD_SEED               8'h1f
`define MSGLD_PATTERN            2'h0
// Word 3
`define MSGLD_ENABLE             1'b0
`define MSGLD_PASID              20'h0
`define MSGLD_EXECUTE_RQ         1'b0
`define MSGLD_PRIV_MODE_RQ       1'b0

`endif

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
	--top-module tb_msgst_ld_tg \
	-f msgst_ld_tg.f \
	-o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
	exit 0
fi

echo "Simulation did not report success"
exit 1

// File: tb_msgst_ld_tg.sv
`timescale 1ns/1ps
`default_nettype none

`include "msgst_ld_tg_defines.svh"

module tb_msgst_ld_tg
	import msgst_ld_pkg::*;
();

	// About 60 words at up to 12 cycles, five times over, plus reset
	localparam int max_cycles = 60 * 12 * 5 + 400;

	logic        fabric_clk;
	logic        fabric_rst_n;
	logic        msgst_cmd_fill;
	logic        msgld_cmd_fill;
	logic        msgst_pld_fill;
	logic [31:0] awaddr;
	logic [2:0]  awprot;
	logic        awvalid;
	logic        awready = 1'b0;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready = 1'b0;
	logic [1:0]  bresp = 2'b00;   // Always OKAY
	logic        bvalid = 1'b0;
	logic        bready;

	logic [31:0] aw_q[$];   // Write addresses in handshake order
	logic [31:0] wd_q[$];
	logic [2:0]  prot_q[$];
	logic [3:0]  strb_q[$];
	int          aw_wait;
	int          w_wait;
	int          b_wait;
	int          aw_cnt;
	int          w_cnt;
	int          b_cnt;
	bit          max_delay;
	bit          aw_hold;
	bit          w_hold;
	bit          b_hold;
	int          stall_cycles;
	int          proto_errors;
	int          errors;
	int          tests_ok;
	int          tests_bad;

	msgst_ld_tg dut0 (.*);

	initial
	begin
		fabric_clk = 1'b0;
		forever #20 fabric_clk = ~fabric_clk;
	end

	initial
	begin
		repeat (max_cycles) @(posedge fabric_clk);
		$display("Timeout: the run did not end within %0d cycles", max_cycles);
		$display("tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// AXI4-Lite write slave
	////////////////////////////////////////////////////////////
	always @(negedge fabric_clk)
	begin
		if (!fabric_rst_n)
		begin
			awready = 1'b0;
			wready  = 1'b0;
			bvalid  = 1'b0;
		end
		else
		begin
			if ((aw_hold && !awvalid) || (w_hold && !wvalid) || (b_hold && !bready))
			begin
				$display("ERROR: a valid or bready dropped before its handshake at %0t", $time);
				proto_errors++;
			end
			if (awvalid && !awready)
			begin
				if (aw_cnt >= (max_delay ? 3 : aw_wait))
					awready = 1'b1;
				else
					aw_cnt++;
			end
			else if (awready && !awvalid)
			begin
				awready = 1'b0;
				aw_cnt  = 0;
				aw_wait = int'($urandom_range(3, 0));
			end
			if (wvalid && !wready)
			begin
				if (w_cnt >= (max_delay ? 3 : w_wait))
					wready = 1'b1;
				else
					w_cnt++;
			end
			else if (wready && !wvalid)
			begin
				wready = 1'b0;
				w_cnt  = 0;
				w_wait = int'($urandom_range(3, 0));
			end
			if (bready && !bvalid)
			begin
				if (b_cnt >= (max_delay ? 3 : b_wait))
					bvalid = 1'b1;
				else
					b_cnt++;
			end
			else if (bvalid && !bready)
			begin
				bvalid = 1'b0;
				b_cnt  = 0;
				b_wait = int'($urandom_range(3, 0));
			end
			// Both sides up, so the rising edge ahead completes the phase
			if (awvalid && awready)
			begin
				aw_q.push_back(awaddr);
				prot_q.push_back(awprot);
			end
			if (wvalid && wready)
			begin
				wd_q.push_back(wdata);
				strb_q.push_back(wstrb);
			end
			aw_hold = awvalid && !awready;
			w_hold  = wvalid && !wready;
			b_hold  = bready && !bvalid;
			if (aw_hold)
				stall_cycles++;
		end
	end

	////////////////////////////////////////////////////////////
	// Expected values and compares
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] region_base(input fill_region_e r);
		case (r)
			region_msgld_cmd: return `MSGLD_CMD_BASE;
			region_msgst_pld: return `MSGST_PLD_BASE;
			default:          return `MSGST_CMD_BASE;
		endcase
	endfunction

	function automatic int region_words(input fill_region_e r);
		case (r)
			region_msgld_cmd: return `MSGLD_CMD_WORDS;
			region_msgst_pld: return `MSGST_PLD_WORDS;
			default:          return `MSGST_CMD_WORDS;
		endcase
	endfunction

	function automatic logic [31:0] expected_word(input fill_region_e r, input int idx);
		logic [31:0] st[6];
		logic [31:0] ld[4];
		st = '{32'h0000_0100, 32'h010f_0000, 32'h0000_37bf, 32'h01f0_0000, 32'h0, 32'h0};
		ld = '{32'h0000_0900, 32'h0000_400a, 32'h000f_8bdf, 32'h0};
		case (r)
			region_msgst_cmd: return st[idx[2:0]];
			region_msgld_cmd: return ld[idx[1:0]];
			default: return {8'(4 * idx + 3), 8'(4 * idx + 2), 8'(4 * idx + 1), 8'(4 * idx)};
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected data 0x%08h, actual 0x%08h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected address 0x%08h, actual 0x%08h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_prot(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected awprot 0x%0h, actual 0x%0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_strb(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected wstrb 0x%0h, actual 0x%0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("CHECK FAILED %s: expected count %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	// Writes from index first on, word k at region index k modulo the length
	task automatic check_fill(input string name, input fill_region_e r, input int n,
		input int first);
		int k;
		int m;
		int idx;
		check_count({name, " addresses"}, n, aw_q.size() - first);
		check_count({name, " data words"}, n, wd_q.size() - first);
		m = (aw_q.size() < wd_q.size()) ? aw_q.size() - first : wd_q.size() - first;
		if (m > n)
			m = n;
		for (k = 0; k < m; k++)
		begin
			idx = k % region_words(r);
			check_addr(name, region_base(r) + 32'(4 * idx), aw_q[first + k]);
			check_word(name, expected_word(r, idx), wd_q[first + k]);
			check_prot(name, 3'b000, prot_q[first + k]);   // Unprivileged data access
			check_strb(name, 4'hf, strb_q[first + k]);
		end
	endtask

	task automatic finish_test(input string name, input int e0);
		int n;
		n = errors + proto_errors - e0;
		if (n == 0)
		begin
			tests_ok++;
			$display("PASS  %s", name);
		end
		else
		begin
			tests_bad++;
			$display("FAIL  %s with %0d errors", name, n);
		end
	endtask

	task automatic pulse_request(input logic st, input logic ld, input logic pl);
		@(negedge fabric_clk);
		msgst_cmd_fill = st;
		msgld_cmd_fill = ld;
		msgst_pld_fill = pl;
		@(negedge fabric_clk);
		msgst_cmd_fill = 1'b0;
		msgld_cmd_fill = 1'b0;
		msgst_pld_fill = 1'b0;
	endtask

	// Exactly one of the three is up while a fill runs
	task automatic wait_bus_idle();
		@(negedge fabric_clk);
		while (awvalid || wvalid || bready)
			@(negedge fabric_clk);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	task automatic reset_idle();
		int e0;
		int busy;
		int first;
		wr_phase_e ph;
		string name;
		e0 = errors + proto_errors;
		busy = 0;
		first = aw_q.size();
		ph = phase_idle;
		name = {"reset_", ph.name()};
		check_addr(name, 32'h0, awaddr);
		check_word(name, 32'h0, wdata);
		repeat (20)
		begin
			@(negedge fabric_clk);
			if (awvalid || wvalid || bready)
				busy++;
		end
		check_count({name, " busy cycles"}, 0, busy);
		check_count({name, " writes"}, 0, aw_q.size() - first);
		finish_test(name, e0);
	endtask

	task automatic store_fill();
		int e0;
		int first;
		e0 = errors + proto_errors;
		first = aw_q.size();
		pulse_request(1'b1, 1'b0, 1'b0);
		wait_bus_idle();
		check_fill("store_fill", region_msgst_cmd, `MSGST_CMD_WORDS, first);
		finish_test("store_fill", e0);
	endtask

	task automatic load_and_payload_fill();
		int e0;
		int first;
		e0 = errors + proto_errors;
		first = aw_q.size();
		pulse_request(1'b0, 1'b1, 1'b0);
		wait_bus_idle();
		check_fill("load_fill", region_msgld_cmd, `MSGLD_CMD_WORDS, first);
		first = aw_q.size();
		pulse_request(1'b0, 1'b0, 1'b1);
		wait_bus_idle();
		check_fill("payload_fill", region_msgst_pld, `MSGST_PLD_WORDS, first);
		finish_test("load_and_payload_fill", e0);
	endtask

	task automatic priority_fill();
		int e0;
		int first;
		e0 = errors + proto_errors;
		first = aw_q.size();
		pulse_request(1'b1, 1'b1, 1'b1);
		wait_bus_idle();
		repeat (10) @(negedge fabric_clk);   // Nothing else may start
		check_fill("priority", region_msgst_cmd, `MSGST_CMD_WORDS, first);
		finish_test("priority", e0);
	endtask

	task automatic wrap_held();
		int e0;
		int first;
		e0 = errors + proto_errors;
		first = aw_q.size();
		@(negedge fabric_clk);
		msgld_cmd_fill = 1'b1;
		while (wd_q.size() - first < 6)
			@(negedge fabric_clk);
		msgld_cmd_fill = 1'b0;
		wait_bus_idle();
		check_fill("wrap_held", region_msgld_cmd, 2 * `MSGLD_CMD_WORDS, first);
		finish_test("wrap_held", e0);
	endtask

	task automatic back_pressure();
		int e0;
		int first;
		int stall0;
		e0 = errors + proto_errors;
		max_delay = 1'b1;
		@(negedge fabric_clk);
		first = aw_q.size();
		stall0 = stall_cycles;
		pulse_request(1'b1, 1'b0, 1'b0);
		wait_bus_idle();
		check_fill("back_pressure", region_msgst_cmd, `MSGST_CMD_WORDS, first);
		check_count("back_pressure address stalls", 3 * `MSGST_CMD_WORDS,
			stall_cycles - stall0);
		max_delay = 1'b0;
		finish_test("back_pressure", e0);
	endtask

	initial
	begin
		void'($urandom(58521));
		fabric_rst_n   = 1'b0;
		msgst_cmd_fill = 1'b0;
		msgld_cmd_fill = 1'b0;
		msgst_pld_fill = 1'b0;
		repeat (5) @(negedge fabric_clk);
		fabric_rst_n = 1'b1;

		reset_idle();
		store_fill();
		load_and_payload_fill();
		priority_fill();
		wrap_held();
		back_pressure();

		$display("Summary: %0d tests ok, %0d tests with errors, %0d errors in all",
			tests_ok, tests_bad, errors + proto_errors);
		if (errors == 0 && proto_errors == 0 && tests_bad == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
